//--- verilog/rv32i_types.sv
package rv32i_types;

    // ==============================
    // Basic types
    // ==============================
    typedef logic [31:0] rv32i_word;

    // Two-bit direction state, ST and WT predict taken
    typedef enum logic [1:0]
    {
        ST,
        WT,
        WN,
        SN
    } bp_state_e;

    // ==============================
    // Register map
    // ==============================
    typedef enum logic [1:0]
    {
        REG_CTRL,
        REG_HITS,
        REG_ALLOCS,
        REG_MISPRED
    } bp_reg_addr_e;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLUSH_BIT  = 1; // Write only, always reads 0

endpackage

//--- verilog/bp_ctrl_if.sv
`timescale 1ns/1ps

interface bp_ctrl_if;

    logic enable;   // Level, predictor active
    logic flush;    // One-cycle pulse, empties the table
    logic hit;      // Fetch matched a used entry
    logic alloc;    // New entry written
    logic mispred;  // Wrong-direction correction applied

    modport regs
    (
        output enable,
        output flush,
        input  hit,
        input  alloc,
        input  mispred
    );

    modport pred
    (
        input  enable,
        input  flush,
        output hit,
        output alloc,
        output mispred
    );

endinterface

//--- verilog/predictor_b.sv
`timescale 1ns/1ps

module predictor_b
#(
    parameter int PRE_B_LEN = 16
)
(
    input  logic                  clk,
    input  logic                  rst,
    // Fetch side
    input  logic                  is_prediction,
    input  rv32i_types::rv32i_word pc_fetch,
    output logic                  br_pred,
    // Execute side
    input  logic                  is_correction,
    input  rv32i_types::rv32i_word pc_correct,
    input  logic                  is_correct,
    // Control and statistics
    bp_ctrl_if.pred               ctrl
);
    import rv32i_types::*;

    localparam int IDX_W = $clog2(PRE_B_LEN);

    // ==============================
    // Table storage
    // ==============================
    logic [PRE_B_LEN-1:0] used;
    logic [29:0]          tag [PRE_B_LEN];
    bp_state_e            state [PRE_B_LEN];
    logic [IDX_W-1:0]     next_new;     // FIFO allocation pointer

    logic                 fetch_hit;
    logic [IDX_W-1:0]     fetch_idx;
    logic                 corr_hit;
    logic [IDX_W-1:0]     corr_idx;

    logic                 active;
    logic                 alloc_req;
    logic                 conflict;
    logic                 do_corr;
    logic                 do_alloc;

    // Highest matching index wins
    function automatic logic [IDX_W:0] lookup(input logic [29:0] word_addr);
        logic [IDX_W:0] res;
        res = '0;
        for (int i = 0; i < PRE_B_LEN; i++)
        begin
            if (used[i] && (tag[i] == word_addr))
            begin
                res = {1'b1, IDX_W'(i)};
            end
        end
        return res;
    endfunction

    function automatic bp_state_e next_state(input bp_state_e cur, input logic correct);
        bp_state_e nxt;
        nxt = cur;
        case (cur)
            ST: nxt = correct ? ST : WT;
            WT: nxt = correct ? ST : WN;
            WN: nxt = correct ? SN : WT;
            SN: nxt = correct ? SN : WN;
            default: nxt = WN;
        endcase
        return nxt;
    endfunction

    // ==============================
    // Tag match
    // ==============================
    always_comb
    begin
        {fetch_hit, fetch_idx} = lookup(pc_fetch[31:2]);
    end

    always_comb
    begin
        {corr_hit, corr_idx} = lookup(pc_correct[31:2]);
    end

    // Update decision
    always_comb
    begin
        active    = ctrl.enable && !ctrl.flush;
        alloc_req = is_prediction && !fetch_hit;
        // Correction aimed at the slot being overwritten this cycle
        conflict  = alloc_req && (corr_idx == next_new);
        do_corr   = active && is_correction && corr_hit && !conflict;
        do_alloc  = active && alloc_req && !do_corr;
    end

    // Prediction output
    always_comb
    begin
        br_pred = 1'b0;
        if (fetch_hit && ctrl.enable)
        begin
            br_pred = (state[fetch_idx] == ST) || (state[fetch_idx] == WT);
        end
    end

    // Statistics pulses
    always_comb
    begin
        ctrl.hit     = is_prediction && ctrl.enable && fetch_hit;
        ctrl.alloc   = do_alloc;
        ctrl.mispred = do_corr && !is_correct;
    end

    // ==============================
    // Table update
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst || ctrl.flush)
        begin
            used     <= '0;
            next_new <= '0;
            for (int i = 0; i < PRE_B_LEN; i++)
            begin
                state[i] <= WN;
            end
        end
        else if (do_corr)
        begin
            state[corr_idx] <= next_state(state[corr_idx], is_correct);
        end
        else if (do_alloc)
        begin
            used[next_new]  <= 1'b1;
            state[next_new] <= WN;
            next_new        <= next_new + 1'b1; // Wraps since the table size is a power of two
        end
    end

    // Tag written on allocation
    always_ff @(posedge clk)
    begin
        if (do_alloc)
        begin
            tag[next_new] <= pc_fetch[31:2];
        end
    end

endmodule

//--- verilog/bp_regs.sv
`timescale 1ns/1ps

module bp_regs
(
    input  logic                      clk,
    input  logic                      rst,
    input  rv32i_types::bp_reg_addr_e reg_addr,
    input  logic                      reg_wr,
    input  rv32i_types::rv32i_word    reg_wdata,
    output rv32i_types::rv32i_word    reg_rdata,
    bp_ctrl_if.regs                   ctrl
);
    import rv32i_types::*;

    logic      enable_q;
    logic      flush_q;
    rv32i_word hit_cnt;
    rv32i_word alloc_cnt;
    rv32i_word mispred_cnt;

    logic      wr_ctrl;
    logic      wr_hits;
    logic      wr_allocs;
    logic      wr_mispred;
    rv32i_word ctrl_word;

    // Write clears, otherwise count the pulse with wraparound
    function automatic rv32i_word cnt_next(input rv32i_word cnt, input logic clr,
                                           input logic inc);
        rv32i_word res;
        res = cnt;
        if (clr)
        begin
            res = '0;
        end
        else if (inc)
        begin
            res = cnt + 32'd1;
        end
        return res;
    endfunction

    // ==============================
    // Write decode
    // ==============================
    always_comb
    begin
        wr_ctrl    = reg_wr && (reg_addr == REG_CTRL);
        wr_hits    = reg_wr && (reg_addr == REG_HITS);
        wr_allocs  = reg_wr && (reg_addr == REG_ALLOCS);
        wr_mispred = reg_wr && (reg_addr == REG_MISPRED);
    end

    // Control register and flush pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end
        else
        begin
            flush_q <= wr_ctrl && reg_wdata[CTRL_FLUSH_BIT]; // High for one cycle only
            if (wr_ctrl)
            begin
                enable_q <= reg_wdata[CTRL_ENABLE_BIT];
            end
        end
    end

    // ==============================
    // Statistics counters
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_cnt     <= '0;
            alloc_cnt   <= '0;
            mispred_cnt <= '0;
        end
        else
        begin
            hit_cnt     <= cnt_next(hit_cnt, wr_hits, ctrl.hit);
            alloc_cnt   <= cnt_next(alloc_cnt, wr_allocs, ctrl.alloc);
            mispred_cnt <= cnt_next(mispred_cnt, wr_mispred, ctrl.mispred);
        end
    end

    assign ctrl.enable = enable_q;
    assign ctrl.flush  = flush_q;

    // Read mux
    always_comb
    begin
        ctrl_word                  = '0;
        ctrl_word[CTRL_ENABLE_BIT] = enable_q; // Flush bit stays 0
    end

    always_comb
    begin
        reg_rdata = '0;
        case (reg_addr)
            REG_CTRL:    reg_rdata = ctrl_word;
            REG_HITS:    reg_rdata = hit_cnt;
            REG_ALLOCS:  reg_rdata = alloc_cnt;
            REG_MISPRED: reg_rdata = mispred_cnt;
            default:     reg_rdata = '0;
        endcase
    end

endmodule

//--- verilog/branch_predictor_top.sv
`timescale 1ns/1ps

module branch_predictor_top
#(
    parameter int PRE_B_LEN = 16
)
(
    input  logic                      clk,
    input  logic                      rst,

    // ==============================
    // Fetch side
    // ==============================
    input  logic                      is_prediction,
    input  rv32i_types::rv32i_word    pc_fetch,
    output logic                      br_pred,

    // ==============================
    // Execute side
    // ==============================
    input  logic                      is_correction,
    input  rv32i_types::rv32i_word    pc_correct,
    input  logic                      is_correct,

    // ==============================
    // Register port
    // ==============================
    input  rv32i_types::bp_reg_addr_e reg_addr,
    input  logic                      reg_wr,
    input  rv32i_types::rv32i_word    reg_wdata,
    output rv32i_types::rv32i_word    reg_rdata
);

    // Enable/flush down, statistics pulses up
    bp_ctrl_if ctrl_if ();

    predictor_b
    #(
        .PRE_B_LEN     (PRE_B_LEN)
    )
    u_predictor
    (
        .clk           (clk),
        .rst           (rst),
        .is_prediction (is_prediction),
        .pc_fetch      (pc_fetch),
        .br_pred       (br_pred),
        .is_correction (is_correction),
        .pc_correct    (pc_correct),
        .is_correct    (is_correct),
        .ctrl          (ctrl_if.pred)
    );

    bp_regs u_regs
    (
        .clk           (clk),
        .rst           (rst),
        .reg_addr      (reg_addr),
        .reg_wr        (reg_wr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .ctrl          (ctrl_if.regs)
    );

endmodule

//--- dv/bp_ref_model.svh
// ==============================
// Reference model state
// ==============================
logic        m_used  [TB_LEN];
logic [29:0] m_tag   [TB_LEN];
bp_state_e   m_state [TB_LEN];
int          m_ptr;         // Next slot to overwrite
logic        m_enable;
logic        m_flush;       // Flush pulse pending for the coming edge
rv32i_word   m_hits;
rv32i_word   m_allocs;
rv32i_word   m_mispred;

// Matching slot or -1, the highest index wins
function automatic int lookup_entry(input rv32i_word pc);
    int idx;
    idx = -1;
    for (int i = 0; i < TB_LEN; i++)
    begin
        if (m_used[i] && (m_tag[i] == pc[31:2]))
            idx = i;
    end
    return idx;
endfunction

function automatic logic predict_taken(input rv32i_word pc);
    int idx;
    idx = lookup_entry(pc);
    if ((idx < 0) || !m_enable)
        return 1'b0;
    return (m_state[idx] == ST) || (m_state[idx] == WT);
endfunction

function automatic bp_state_e corrected_state(input bp_state_e cur, input logic ok);
    bp_state_e res;
    if (ok)
        res = (cur == WT) ? ST : ((cur == WN) ? SN : cur);  // Strengthen
    else
    begin
        case (cur)
            ST:      res = WT;
            WT:      res = WN;
            WN:      res = WT;
            default: res = WN;
        endcase
    end
    return res;
endfunction

function automatic void flush_table();
    for (int i = 0; i < TB_LEN; i++)
    begin
        m_used[i]  = 1'b0;
        m_state[i] = WN;
    end
    m_ptr = 0;
endfunction

function automatic void allocate_entry(input rv32i_word pc);
    m_used[m_ptr]  = 1'b1;
    m_tag[m_ptr]   = pc[31:2];
    m_state[m_ptr] = WN;
    m_ptr          = (m_ptr + 1) % TB_LEN;
endfunction

function automatic void reset_model();
    flush_table();
    m_enable  = 1'b1;
    m_flush   = 1'b0;
    m_hits    = '0;
    m_allocs  = '0;
    m_mispred = '0;
endfunction

function automatic rv32i_word read_register(input bp_reg_addr_e addr);
    rv32i_word val;
    val = '0;
    case (addr)
        REG_CTRL:   val[CTRL_ENABLE_BIT] = m_enable;
        REG_HITS:   val = m_hits;
        REG_ALLOCS: val = m_allocs;
        default:    val = m_mispred;
    endcase
    return val;
endfunction

// One rising edge, with the inputs sampled there
function automatic void advance_model(input logic pred, input rv32i_word pc_f,
                                      input logic corr, input rv32i_word pc_c,
                                      input logic ok, input bp_reg_addr_e addr,
                                      input logic wr, input rv32i_word wdata);
    int   fi;
    int   ci;
    logic miss;
    logic do_corr;
    logic do_alloc;
    logic hit;
    fi       = lookup_entry(pc_f);
    ci       = lookup_entry(pc_c);
    miss     = pred && (fi < 0);
    // Correction on the slot a same-cycle miss overwrites is lost
    do_corr  = m_enable && !m_flush && corr && (ci >= 0) && !(miss && (ci == m_ptr));
    do_alloc = m_enable && !m_flush && miss && !do_corr;
    hit      = pred && m_enable && (fi >= 0);

    m_hits    = (wr && (addr == REG_HITS))    ? '0 : m_hits + hit;
    m_allocs  = (wr && (addr == REG_ALLOCS))  ? '0 : m_allocs + do_alloc;
    m_mispred = (wr && (addr == REG_MISPRED)) ? '0 : m_mispred + (do_corr && !ok);

    if (m_flush)
        flush_table();
    else if (do_corr)
        m_state[ci] = corrected_state(m_state[ci], ok);
    else if (do_alloc)
        allocate_entry(pc_f);

    if (wr && (addr == REG_CTRL))
        m_enable = wdata[CTRL_ENABLE_BIT];
    m_flush = wr && (addr == REG_CTRL) && wdata[CTRL_FLUSH_BIT];
endfunction

//--- dv/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;
    import rv32i_types::*;

    localparam int TB_LEN          = 16;
    localparam int SEED            = 31891;
    localparam int POOL_SIZE       = 24;
    localparam int RAND_CYCLES     = 3000;
    localparam int DIRECTED_CYCLES = 200;   // Reset and directed tests with margin
    localparam int CYCLE_LIMIT     = 2 * (RAND_CYCLES + DIRECTED_CYCLES);
    localparam logic [4:0] WALK_OK = 5'b01001;

    logic         clk;
    logic         rst;
    logic         is_prediction;
    rv32i_word    pc_fetch;
    logic         br_pred;
    logic         is_correction;
    rv32i_word    pc_correct;
    logic         is_correct;
    bp_reg_addr_e reg_addr;
    logic         reg_wr;
    rv32i_word    reg_wdata;
    rv32i_word    reg_rdata;

    rv32i_word    pool [POOL_SIZE];
    bp_state_e    walk_exp [5] = '{SN, WN, WT, ST, WT};
    int           cycle_count = 0;

    `include "bp_ref_model.svh"

    branch_predictor_top #(.PRE_B_LEN(TB_LEN)) dut0 (.*);

    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_pred(input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error at %0d ns: br_pred expected %0b, got %0b", $time, exp, act);
            stop_failed();
        end
    endtask

    task automatic compare_word(input string name, input rv32i_word exp, input rv32i_word act);
        if (act !== exp)
        begin
            $display("Error at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic match_state(input string name, input bp_state_e exp, input bp_state_e act);
        if (act !== exp)
        begin
            $display("Error at %0d ns: %s expected %s, got %s", $time, name, exp.name(),
                     act.name());
            stop_failed();
        end
    endtask

    // Drives at the current falling edge and holds for one cycle
    task automatic apply_cycle(input logic pred, input rv32i_word pcf, input logic corr,
                               input rv32i_word pcc, input logic ok, input bp_reg_addr_e addr,
                               input logic wr, input rv32i_word wdata);
        is_prediction <= pred;
        pc_fetch      <= pcf;
        is_correction <= corr;
        pc_correct    <= pcc;
        is_correct    <= ok;
        reg_addr      <= addr;
        reg_wr        <= wr;
        reg_wdata     <= wdata;
        @(negedge clk);
    endtask

    task automatic fetch_pc(input rv32i_word pc);
        apply_cycle(1'b1, pc, 1'b0, '0, 1'b0, REG_HITS, 1'b0, '0);
    endtask

    task automatic correct_pc(input rv32i_word pc, input logic ok);
        apply_cycle(1'b0, pc, 1'b1, pc, ok, REG_MISPRED, 1'b0, '0);  // Fetch shows the result
    endtask

    task automatic write_reg(input bp_reg_addr_e addr, input rv32i_word data);
        apply_cycle(1'b0, '0, 1'b0, '0, 1'b0, addr, 1'b1, data);
    endtask

    task automatic expect_reg(input bp_reg_addr_e addr, input rv32i_word exp);
        apply_cycle(1'b0, '0, 1'b0, '0, 1'b0, addr, 1'b0, '0);
        compare_word(addr.name(), exp, reg_rdata);
    endtask

    // ==============================
    // Model, checker, timeout
    // ==============================
    always @(posedge clk)
    begin
        if (!rst)
            advance_model(is_prediction, pc_fetch, is_correction, pc_correct, is_correct,
                          reg_addr, reg_wr, reg_wdata);
    end

    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_pred(predict_taken(pc_fetch), br_pred);
            compare_word("reg_rdata", read_register(reg_addr), reg_rdata);
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_failed();
        end
    end

    initial
    begin
        int        idx;
        rv32i_word pc_a;
        rv32i_word pc_b;
        rv32i_word victim;
        logic      pred_r;
        logic      corr_r;
        logic      ok_r;
        rv32i_word pcf_r;
        rv32i_word pcc_r;
        clk           = 1'b0;
        rst           = 1'b1;
        is_prediction = 1'b0;
        pc_fetch      = '0;
        is_correction = 1'b0;
        pc_correct    = '0;
        is_correct    = 1'b0;
        reg_addr      = REG_CTRL;
        reg_wr        = 1'b0;
        reg_wdata     = '0;
        void'($urandom(SEED));
        for (int i = 0; i < POOL_SIZE; i++)
            pool[i] = {16'($urandom()), 8'(i), 8'h00};  // Distinct word addresses
        reset_model();
        repeat (10) @(negedge clk);
        rst <= 1'b0;

        // 1. Unseen PC allocates as WN
        pc_a = 32'h0000_0100;
        fetch_pc(pc_a);
        check_pred(1'b0, br_pred);
        fetch_pc(pc_a);
        idx = lookup_entry(pc_a);
        if (idx < 0)
        begin
            $display("Model holds no entry for the allocated PC");
            stop_failed();
        end
        match_state("model state", WN, m_state[idx]);
        expect_reg(REG_ALLOCS, 32'd1);

        // 2. Walk through all four states
        for (int i = 0; i < 5; i++)
        begin
            correct_pc(pc_a, WALK_OK[i]);
            match_state("model state", walk_exp[i], m_state[idx]);
            check_pred(walk_exp[i] inside {ST, WT}, br_pred);
        end
        expect_reg(REG_MISPRED, 32'd3);

        // 3. Seventeen PCs through sixteen slots evict the first one
        for (int i = 0; i < 17; i++)
            fetch_pc(32'h0000_2000 + 32'(i) * 4);
        write_reg(REG_HITS, '0);
        for (int i = 1; i < 17; i++)
            fetch_pc(32'h0000_2000 + 32'(i) * 4);
        expect_reg(REG_HITS, 32'd16);
        fetch_pc(32'h0000_2000);
        expect_reg(REG_HITS, 32'd16);

        // 4. Correction on the slot under the pointer during a miss
        pc_b   = 32'h0000_3000;
        victim = {m_tag[m_ptr], 2'b00};
        write_reg(REG_MISPRED, '0);
        apply_cycle(1'b1, pc_b, 1'b1, victim, 1'b0, REG_MISPRED, 1'b0, '0);
        expect_reg(REG_MISPRED, '0);
        write_reg(REG_HITS, '0);
        fetch_pc(pc_b);
        fetch_pc(victim);
        expect_reg(REG_HITS, 32'd1);

        // 5. Enable off, back on, then flush
        correct_pc(pc_b, 1'b0);
        check_pred(1'b1, br_pred);
        write_reg(REG_CTRL, '0);
        write_reg(REG_HITS, '0);
        write_reg(REG_ALLOCS, '0);
        fetch_pc(pc_b);
        check_pred(1'b0, br_pred);
        fetch_pc(32'h0000_4000);
        expect_reg(REG_HITS, '0);
        expect_reg(REG_ALLOCS, '0);
        write_reg(REG_CTRL, 32'd1);
        fetch_pc(pc_b);
        check_pred(1'b1, br_pred);
        write_reg(REG_CTRL, 32'd3);
        write_reg(REG_HITS, '0);        // Flush cycle
        expect_reg(REG_CTRL, 32'd1);
        fetch_pc(pc_b);
        check_pred(1'b0, br_pred);
        fetch_pc(pc_a);
        check_pred(1'b0, br_pred);
        for (int i = 0; i < 17; i++)
        begin
            fetch_pc(32'h0000_2000 + 32'(i) * 4);
            check_pred(1'b0, br_pred);
        end
        expect_reg(REG_HITS, '0);

        // 6. Random traffic
        for (int n = 0; n < RAND_CYCLES; n++)
        begin
            pred_r = $urandom_range(0, 9) < 7;
            pcf_r  = pool[$urandom_range(0, POOL_SIZE - 1)];
            corr_r = $urandom_range(0, 9) < 4;
            pcc_r  = pool[$urandom_range(0, POOL_SIZE - 1)];
            ok_r   = 1'($urandom_range(0, 1));
            apply_cycle(pred_r, pcf_r, corr_r, pcc_r, ok_r,
                        bp_reg_addr_e'($urandom_range(0, 3)), 1'b0, '0);
        end
        apply_cycle(1'b0, '0, 1'b0, '0, 1'b0, REG_CTRL, 1'b0, '0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
verilog/rv32i_types.sv
verilog/bp_ctrl_if.sv
verilog/predictor_b.sv
verilog/bp_regs.sv
verilog/branch_predictor_top.sv
dv/tb_branch_predictor.sv
